// File: Makefile
# Verilator build for the capture target testbench

VERILATOR ?= verilator
TOP       ?= tb_capt_target
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass only when the pass message appears in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: design/byte_loader.sv
/*
  Shifts host bytes into key and data, last four strobes form a word.
  go is dropped while the core is busy or start is already pending.
*/
`timescale 1ns/1ps
`include "capt_defs.svh"

module byte_loader (
  input  logic             clk_main_i,
  input  logic             arst_n_i,
  input  capt_pkg::byte_t  byte_i,        // Host byte
  input  logic             byte_stb_i,    // Shift byte_i in
  input  logic             byte_is_key_i, // 1 selects key, 0 selects data
  input  logic             go_i,          // Request one operation
  capt_if.ldr              bus
);

  import capt_pkg::*;

  word_t key_sr;   // Key shift register
  word_t data_sr;  // Data shift register
  word_t key_q;    // Key snapshot for the core
  word_t data_q;   // Data snapshot for the core
  logic  start_q;
  logic  go_ok;

  // Core free and no start in flight
  assign go_ok = go_i & ~bus.busy & ~start_q;

  //////////////////////////////////////////////////////////////////////
  // Byte shift registers
  //////////////////////////////////////////////////////////////////////

  // New byte enters at the low end, older bytes move up
  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      key_sr  <= '0;
      data_sr <= '0;
    end else if (byte_stb_i) begin
      if (byte_is_key_i) begin
        key_sr <= {key_sr[`CAPT_WORD_W-`CAPT_BYTE_W-1:0], byte_i};
      end else begin
        data_sr <= {data_sr[`CAPT_WORD_W-`CAPT_BYTE_W-1:0], byte_i};
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand snapshot and start
  //////////////////////////////////////////////////////////////////////

  // Snapshot takes the shift values before a same-cycle strobe
  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      key_q   <= '0;
      data_q  <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= go_ok; // Cycle 1 after go
      if (go_ok) begin
        key_q  <= key_sr;
        data_q <= data_sr;
      end
    end
  end

  assign bus.key   = key_q;
  assign bus.data  = data_q;
  assign bus.start = start_q;

  // Back-to-back starts would hit the core while it loads
  a_start_single : assert property (
    @(posedge clk_main_i) disable iff (!arst_n_i) start_q |=> !start_q
  );

endmodule

// File: design/capt_defs.svh
/*
  Widths and round count of the capture target.
  CAPT_ROUNDS must stay in 2..15 to fit the 4-bit round counter.
*/
`ifndef CAPT_DEFS_SVH
`define CAPT_DEFS_SVH

// Operand and result width
`define CAPT_WORD_W 32

// Host byte width, one strobe per byte
`define CAPT_BYTE_W 8

// Number of cipher rounds
// Also busy and trigger length in cycles
`define CAPT_ROUNDS 8

`endif

// File: design/capt_if.sv
/*
  Operand and status bundle between loader, round core and trigger gate.
  No clock inside, all sampling happens in the blocks.
*/
`timescale 1ns/1ps

interface capt_if;

  import capt_pkg::*;

  // Loader side
  word_t data;   // Data operand, stable while busy
  word_t key;    // Key operand, stable while busy
  logic  start;  // One-cycle pulse

  // Core side
  logic  busy;   // High for CAPT_ROUNDS cycles
  logic  done;   // Pulse in last busy cycle
  word_t result; // Valid with done

  // Byte loader, needs busy to drop go
  modport ldr (
    output data,
    output key,
    output start,
    input  busy
  );

  // Round core
  modport core (
    input  data,
    input  key,
    input  start,
    output busy,
    output done,
    output result
  );

  // Trigger gate, observes only
  modport gate (
    input busy,
    input done,
    input result
  );

endinterface

// File: design/capt_pkg.sv
/*
  Shared types of the capture target.
  Widths come from capt_defs.svh.
*/
`include "capt_defs.svh"

package capt_pkg;

  // One operand or result word
  typedef logic [`CAPT_WORD_W-1:0] word_t;

  // One host byte
  typedef logic [`CAPT_BYTE_W-1:0] byte_t;

  // Round counter, holds 0..15
  typedef logic [3:0] round_t;

  // Round core FSM
  typedef enum logic {
    IDLE = 1'b0, // Waiting for start
    RUN  = 1'b1  // One round per cycle
  } core_state_e;

endpackage

// File: design/capt_target_top.sv
/*
  Capture target top, single clock domain.
  go to result_valid_o latency is CAPT_ROUNDS+2 cycles.
*/
`timescale 1ns/1ps

module capt_target_top (
  input  logic            clk_main_i,
  input  logic            arst_n_i,
  // Host byte port
  input  capt_pkg::byte_t byte_i,
  input  logic            byte_stb_i,
  input  logic            byte_is_key_i,
  input  logic            go_i,
  // Scope trigger request
  input  logic            trig_req_i,
  // Outputs to capture board
  output logic            trig_o,
  output capt_pkg::word_t result_o,
  output logic            result_valid_o
);

  //////////////////////////////////////////////////////////////////////
  // Internal bundle and blocks
  //////////////////////////////////////////////////////////////////////

  capt_if i_bus ();

  // Host bytes in, operands and start out
  byte_loader i_loader (
    .clk_main_i    (clk_main_i),
    .arst_n_i      (arst_n_i),
    .byte_i        (byte_i),
    .byte_stb_i    (byte_stb_i),
    .byte_is_key_i (byte_is_key_i),
    .go_i          (go_i),
    .bus           (i_bus.ldr)
  );

  // Cipher rounds
  round_core i_core (
    .clk_main_i (clk_main_i),
    .arst_n_i   (arst_n_i),
    .bus        (i_bus.core)
  );

  // Precise trigger and result capture
  trigger_gate i_gate (
    .clk_main_i     (clk_main_i),
    .arst_n_i       (arst_n_i),
    .trig_req_i     (trig_req_i),
    .bus            (i_bus.gate),
    .trig_o         (trig_o),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

endmodule

// File: design/round_core.sv
/*
  Toy round cipher, one round per cycle, no real security.
  Takes every start pulse, the loader must hold start off while busy.
*/
`timescale 1ns/1ps
`include "capt_defs.svh"

module round_core (
  input  logic clk_main_i,
  input  logic arst_n_i,
  capt_if.core bus
);

  import capt_pkg::*;

  localparam round_t LastRound = round_t'(`CAPT_ROUNDS);

  // Rotate left by 3, add key, add round number in low bits
  function automatic word_t round_fn(word_t s, word_t k, round_t r);
    word_t rot;
    rot = {s[`CAPT_WORD_W-4:0], s[`CAPT_WORD_W-1:`CAPT_WORD_W-3]};
    return rot ^ k ^ word_t'(r);
  endfunction

  core_state_e state_q;
  round_t      cnt_q;  // Rounds already applied
  word_t       st_q;   // Cipher state

  //////////////////////////////////////////////////////////////////////
  // Round FSM
  //////////////////////////////////////////////////////////////////////

  // Round 1 is applied on the start edge
  // so st_q holds the final state in the last busy cycle
  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      st_q    <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (bus.start) begin
            st_q    <= round_fn(bus.data ^ bus.key, bus.key, round_t'(1));
            cnt_q   <= round_t'(1);
            state_q <= RUN;
          end
        end
        RUN: begin
          if (cnt_q == LastRound) begin
            state_q <= IDLE; // Result shown this cycle
          end else begin
            st_q  <= round_fn(st_q, bus.key, cnt_q + round_t'(1));
            cnt_q <= cnt_q + round_t'(1);
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Status outputs
  //////////////////////////////////////////////////////////////////////

  assign bus.busy   = (state_q == RUN);
  assign bus.done   = (state_q == RUN) && (cnt_q == LastRound); // Last busy cycle
  assign bus.result = st_q;

  // Loader gating keeps start away from a running core
  a_no_start_busy : assert property (
    @(posedge clk_main_i) disable iff (!arst_n_i) bus.start |-> !bus.busy
  );

endmodule

// File: design/trigger_gate.sv
/*
  Scope trigger qualified by busy, one cycle behind the core.
  result_o holds until the next done.
*/
`timescale 1ns/1ps

module trigger_gate (
  input  logic            clk_main_i,
  input  logic            arst_n_i,
  input  logic            trig_req_i,     // Host trigger request
  capt_if.gate            bus,
  output logic            trig_o,         // To capture scope
  output capt_pkg::word_t result_o,
  output logic            result_valid_o  // One-cycle pulse
);

  import capt_pkg::*;

  logic  trig_q;
  logic  valid_q;
  word_t result_q;

  //////////////////////////////////////////////////////////////////////
  // Trigger and result registers
  //////////////////////////////////////////////////////////////////////

  // Request forwarded only while the cipher computes
  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trig_q   <= 1'b0;
      valid_q  <= 1'b0;
      result_q <= '0;
    end else begin
      trig_q  <= bus.busy & trig_req_i;
      valid_q <= bus.done;
      if (bus.done) begin
        result_q <= bus.result; // Kept until next done
      end
    end
  end

  assign trig_o         = trig_q;
  assign result_o       = result_q;
  assign result_valid_o = valid_q;

  // One done per operation from the core
  a_valid_single : assert property (
    @(posedge clk_main_i) disable iff (!arst_n_i) result_valid_o |=> !result_valid_o
  );

endmodule

// File: sim/tb_capt_target.sv
/*
  Testbench for capt_target_top with LFSR stimulus and a cipher model.
  Outputs are sampled 10 ns after the rising edge, where inputs also change.
*/
`timescale 1ns/1ps
`include "capt_defs.svh"

module tb_capt_target;

  import capt_pkg::*;

  localparam int NumOps   = 11;
  localparam int OpCycles = `CAPT_ROUNDS + 40;  // Per-operation budget
  localparam int WdCycles = NumOps * OpCycles + 200;

  logic  clk_main_i;
  logic  arst_n_i;
  byte_t byte_i;
  logic  byte_stb_i;
  logic  byte_is_key_i;
  logic  go_i;
  logic  trig_req_i;
  logic  trig_o;
  word_t result_o;
  logic  result_valid_o;

  logic [15:0] lfsr_q = 16'd63;
  word_t       key_m;   // Tracked key
  word_t       data_m;  // Tracked data
  int          err_cnt = 0;
  int          op_cnt = 0;

  capt_target_top i_dut (
    .clk_main_i     (clk_main_i),
    .arst_n_i       (arst_n_i),
    .byte_i         (byte_i),
    .byte_stb_i     (byte_stb_i),
    .byte_is_key_i  (byte_is_key_i),
    .go_i           (go_i),
    .trig_req_i     (trig_req_i),
    .trig_o         (trig_o),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

  initial begin
    clk_main_i = 1'b0;
    forever #50 clk_main_i = ~clk_main_i;  // 100 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR with taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // Rotate left 3, XOR key, XOR round number
  function automatic word_t cipher_model(input word_t d, input word_t k);
    word_t s;
    s = d ^ k;
    for (int r = 1; r <= `CAPT_ROUNDS; r++) begin
      s = (s << 3) | (s >> (`CAPT_WORD_W - 3));
      s = s ^ k ^ word_t'(r);
    end
    return s;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Drive helpers
  //////////////////////////////////////////////////////////////////////

  task automatic tick();
    @(posedge clk_main_i);
    #10;
  endtask

  // One byte strobe and the same shift in the model
  task automatic strobe_byte(input bit is_key, input byte_t b);
    byte_i        = b;
    byte_is_key_i = is_key;
    byte_stb_i    = 1'b1;
    if (is_key) key_m = {key_m[`CAPT_WORD_W-`CAPT_BYTE_W-1:0], b};
    else data_m = {data_m[`CAPT_WORD_W-`CAPT_BYTE_W-1:0], b};
    tick();
    byte_stb_i = 1'b0;
  endtask

  // Load operands, pulse go, watch result and trigger until window ends
  task automatic run_op(input string name, input bit new_key, input int n_data,
                        input bit req, input bit extra_go);
    word_t exp;
    int    t;
    int    valid_at;
    int    valid_cnt;
    int    trig_cnt;
    if (new_key) begin
      for (int i = 0; i < 4; i++) strobe_byte(1'b1, byte_t'(rand_bits(8)));
    end
    for (int i = 0; i < n_data; i++) strobe_byte(1'b0, byte_t'(rand_bits(8)));
    exp        = cipher_model(data_m, key_m);
    trig_req_i = req;
    go_i       = 1'b1;
    t          = 0;
    valid_at   = 0;
    valid_cnt  = 0;
    trig_cnt   = 0;
    while (t < OpCycles && (valid_at == 0 || t < valid_at + `CAPT_ROUNDS)) begin
      tick();
      t++;
      go_i = extra_go && (t == 3);  // Lands while busy
      if (trig_o) trig_cnt++;
      if (result_valid_o) begin
        valid_cnt++;
        if (valid_at == 0) begin
          valid_at = t;
          assert (result_o == exp) else begin
            $display("Fail %s result: expected %h, actual %h", name, exp, result_o);
            err_cnt++;
          end
        end
      end
    end
    assert (valid_at != 0) else begin
      $display("%s: no result_valid_o pulse within %0d cycles of go", name, OpCycles);
      err_cnt++;
    end
    if (valid_at != 0) begin
      assert (valid_at == `CAPT_ROUNDS + 2) else begin
        $display("Fail %s latency: expected %0d, actual %0d", name, `CAPT_ROUNDS + 2,
                 valid_at);
        err_cnt++;
      end
    end
    assert (valid_cnt <= 1) else begin
      $display("%s: result_valid_o pulsed %0d times for one operation", name, valid_cnt);
      err_cnt++;
    end
    assert (trig_cnt == (req ? `CAPT_ROUNDS : 0)) else begin
      $display("Fail %s trigger cycles: expected %0d, actual %0d", name,
               req ? `CAPT_ROUNDS : 0, trig_cnt);
      err_cnt++;
    end
    assert (result_o == exp) else begin
      $display("Fail %s hold: expected %h, actual %h", name, exp, result_o);
      err_cnt++;
    end
    trig_req_i = 1'b0;
    op_cnt++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    arst_n_i      = 1'b0;
    byte_i        = '0;
    byte_stb_i    = 1'b0;
    byte_is_key_i = 1'b0;
    go_i          = 1'b0;
    trig_req_i    = 1'b0;
    key_m         = '0;
    data_m        = '0;
    repeat (4) @(posedge clk_main_i);
    #10;
    arst_n_i = 1'b1;

    // Quiet outputs after reset with no go
    for (int i = 0; i < 10; i++) begin
      tick();
      assert (trig_o == 1'b0) else begin
        $display("Fail reset trig_o: expected 0, actual %b", trig_o);
        err_cnt++;
      end
      assert (result_valid_o == 1'b0) else begin
        $display("Fail reset result_valid_o: expected 0, actual %b", result_valid_o);
        err_cnt++;
      end
      assert (result_o == '0) else begin
        $display("Fail reset result_o: expected %h, actual %h", word_t'(0), result_o);
        err_cnt++;
      end
    end

    for (int i = 0; i < 6; i++) begin
      run_op("random", 1'b1, 4, rand_bits(1) != 0, 1'b0);
    end
    run_op("trig_on", 1'b1, 4, 1'b1, 1'b0);
    run_op("trig_off", 1'b1, 4, 1'b0, 1'b0);
    run_op("drop_go", 1'b1, 4, 1'b1, 1'b1);
    run_op("key_keep5", 1'b0, 5, 1'b0, 1'b0);  // Old key and last 4 of 5 bytes
    run_op("key_keep7", 1'b0, 7, 1'b1, 1'b0);

    $display("Operations: %0d, errors: %0d", op_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Bounded run time
  initial begin
    #(WdCycles * 100);
    $display("Watchdog expired after %0d cycles, test did not complete", WdCycles);
    $display("Operations: %0d, errors: %0d", op_cnt, err_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: tb.f
+incdir+design
design/capt_pkg.sv
design/capt_if.sv
design/byte_loader.sv
design/round_core.sv
design/trigger_gate.sv
design/capt_target_top.sv
sim/tb_capt_target.sv
